// File: tag_pkg.sv
// shared constants and types for a two-client tag network; client ids are 1 bit and lengths 4 bits
package tag_pkg;

   // clients hanging off the master
   localparam int num_clients_lp = 2;

   // packet header field widths
   localparam int tag_len_width_lp = 4;
   localparam int client_id_width_lp = 1;

   // configuration value widths, one per client instance
   localparam int client0_width_lp = 8;
   localparam int client1_width_lp = 12;

   // client address carried in the header
   typedef logic [client_id_width_lp-1:0] client_id_t;

   // payload length, 1 to 15 bits, zero means drop the packet
   typedef logic [tag_len_width_lp-1:0] tag_len_t;

   // values presented on the receive side
   typedef logic [client0_width_lp-1:0] client0_data_t;
   typedef logic [client1_width_lp-1:0] client1_data_t;

   // master packet decoder states, in header order
   typedef enum logic [2:0]
   {
      idle,
      len,
      dnr,
      id,
      payload
   } tag_state_e;

endpackage

// File: tag_if.sv
// one client link; en_i must only change while no packet is in flight on the link
`timescale 1ns/1ps

interface tag_if
(
   input logic clk_i,
   input logic en_i
);

   // op high means shift param in as data
   // op low with param high is a reset, both low is a no-op
   logic op;
   logic param;

   // master only drives the op/param pair
   modport master
   (
      output op,
      output param
   );

   // client sees the clock and enable as well
   modport client
   (
      input clk_i,
      input en_i,
      input op,
      input param
   );

endinterface

// File: tag_sync.sv
// single-bit toggle crossing; send_i must be a one-cycle pulse spaced wider than two recv cycles
`timescale 1ns/1ps

module tag_sync
(
   input  logic tag_clk_i,
   input  logic tag_reset_i,
   input  logic send_i,
   input  logic recv_clk_i,
   input  logic arst_n_i,
   output logic toggle_tag_o,
   output logic toggle_recv_o
);

   logic toggle_r;
   logic sync1_r;
   logic sync2_r;

   // launch flop in the tag domain
   // flips once per send, a reset op pulls it back to zero
   always_ff @(posedge tag_clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         toggle_r <= 1'b0;
      else if (tag_reset_i)
         toggle_r <= 1'b0;
      else if (send_i)
         toggle_r <= ~toggle_r;
   end

   // two flop synchronizer, recv domain
   always_ff @(posedge recv_clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         sync1_r <= 1'b0;
         sync2_r <= 1'b0;
      end
      else
      begin
         sync1_r <= toggle_r;
         sync2_r <= sync1_r;
      end
   end

   assign toggle_tag_o  = toggle_r;
   assign toggle_recv_o = sync2_r;

   // toggle only moves on a send or a reset op
   a_toggle_stable : assert property (@(posedge tag_clk_i) disable iff (!arst_n_i)
      (!send_i && !tag_reset_i) |=> $stable(toggle_r));

endmodule

// File: tag_client.sv
// one configuration value; payload arrives lsb first, and back-to-back sends may merge into one update
`timescale 1ns/1ps

module tag_client
#(
   parameter int width_p = 8
)
(
   tag_if.client              tag_i,
   input  logic               recv_clk_i,
   input  logic               arst_n_i,
   output logic               recv_new_r_o,
   output logic [width_p-1:0] recv_data_r_o
);

   logic               op_r;
   logic               op_r_r;
   logic               param_r;
   logic               reset_op;
   logic               shift_op;
   logic               no_op;
   logic               send_now;
   logic [width_p-1:0] tag_data_r;
   logic [width_p-1:0] tag_data_shift;
   logic               recv_toggle_n;
   logic               recv_toggle_r;
   logic               recv_new;
   logic               recv_new_r;
   logic               recv_new_r_r;
   logic [width_p-1:0] recv_data_r;

   // one tag clock register stage on the incoming op/param pair
   // op_r_r remembers whether the previous op was a shift
   always_ff @(posedge tag_i.clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         op_r    <= 1'b0;
         op_r_r  <= 1'b0;
         param_r <= 1'b0;
      end
      else
      begin
         op_r    <= tag_i.op;
         param_r <= tag_i.param;
         op_r_r  <= op_r;
      end
   end

   // op decode
   assign reset_op = ~op_r & param_r;
   assign shift_op = op_r;
   assign no_op    = ~op_r & ~param_r;

   // send fires at the end of a shift run when tag_data_r is complete and stays put
   // the launch flop adds one more tag cycle before the crossing
   assign send_now = op_r_r & no_op;

   // new bit enters at the top, so the first bit sent ends up in bit 0
   if (width_p == 1)
   begin : g_single
      assign tag_data_shift = param_r;
   end
   else
   begin : g_multi
      assign tag_data_shift = {param_r, tag_data_r[width_p-1:1]};
   end

   // payload shift register is refilled completely by every data packet
   always_ff @(posedge tag_i.clk_i)
   begin
      if (shift_op)
         tag_data_r <= tag_data_shift;
   end

   // toggle launch and resync into recv_clk_i
   tag_sync u_sync
   (
      .tag_clk_i     (tag_i.clk_i),
      .tag_reset_i   (reset_op),
      .send_i        (send_now),
      .recv_clk_i    (recv_clk_i),
      .arst_n_i      (arst_n_i),
      .toggle_tag_o  (),
      .toggle_recv_o (recv_toggle_n)
   );

   // a toggle edge means fresh data; en detaches the client from the network
   assign recv_new = (recv_toggle_r ^ recv_toggle_n) & tag_i.en_i;

   // extra pipeline stage keeps the data register fanout off the sync path
   always_ff @(posedge recv_clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         recv_toggle_r <= 1'b0;
         recv_new_r    <= 1'b0;
         recv_new_r_r  <= 1'b0;
      end
      else
      begin
         recv_toggle_r <= recv_toggle_n;
         recv_new_r    <= recv_new;
         recv_new_r_r  <= recv_new_r;
      end
   end

   // tag_data_r has been still for several tag cycles when this loads
   always_ff @(posedge recv_clk_i)
   begin
      if (recv_new_r)
         recv_data_r <= tag_data_r;
   end

   // gate after the flop so a stopped recv clock cannot leave the pulse stuck high
   assign recv_new_r_o  = recv_new_r_r & tag_i.en_i;
   assign recv_data_r_o = recv_data_r;

   // one pulse per update
   a_new_single : assert property (@(posedge recv_clk_i) disable iff (!arst_n_i)
      recv_new_r_o |=> !recv_new_r_o);

endmodule

// File: tag_master.sv
// serial packet decoder; the line must idle low between packets and a zero length packet is dropped
`timescale 1ns/1ps

module tag_master
   import tag_pkg::*;
(
   input  logic  bsg_tag_i,
   input  logic  arst_n_i,
   input  logic  tag_data_i,
   tag_if.master client_o [num_clients_lp]
);

   tag_state_e                state_r;
   tag_len_t                  len_r;
   tag_len_t                  cnt_r;
   logic                      dnr_r;
   client_id_t                id_r;
   logic [num_clients_lp-1:0] op_n;
   logic [num_clients_lp-1:0] param_n;
   logic [num_clients_lp-1:0] op_r;
   logic [num_clients_lp-1:0] param_r;

   // next op/param per client
   // only the addressed client sees traffic, and only during payload bits
   always_comb
   begin
      op_n    = '0;
      param_n = '0;
      if (state_r == payload)
      begin
         op_n[id_r]    = dnr_r;
         // reset packets turn every slot into a reset, bit value ignored
         param_n[id_r] = dnr_r ? tag_data_i : 1'b1;
      end
   end

   // header walk and payload countdown
   always_ff @(posedge bsg_tag_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_r <= idle;
         len_r   <= '0;
         cnt_r   <= '0;
         dnr_r   <= 1'b0;
         id_r    <= '0;
         op_r    <= '0;
         param_r <= '0;
      end
      else
      begin
         op_r    <= op_n;
         param_r <= param_n;
         case (state_r)
            idle:
            begin
               // start bit
               if (tag_data_i)
               begin
                  state_r <= len;
                  cnt_r   <= '0;
               end
            end
            len:
            begin
               // length arrives lsb first
               len_r <= {tag_data_i, len_r[tag_len_width_lp-1:1]};
               cnt_r <= cnt_r + 1'b1;
               if (cnt_r == tag_len_t'(tag_len_width_lp - 1))
                  state_r <= dnr;
            end
            dnr:
            begin
               dnr_r   <= tag_data_i;
               state_r <= id;
            end
            id:
            begin
               id_r  <= client_id_t'(tag_data_i);
               cnt_r <= len_r;
               // nothing to deliver for length zero
               if (len_r == '0)
                  state_r <= idle;
               else
                  state_r <= payload;
            end
            payload:
            begin
               cnt_r <= cnt_r - 1'b1;
               // back to idle right after the last bit so a new start bit is seen next
               if (cnt_r == tag_len_t'(1))
                  state_r <= idle;
            end
            default:
            begin
               state_r <= idle;
            end
         endcase
      end
   end

   // fan the registered levels out to each link
   for (genvar i = 0; i < num_clients_lp; i++)
   begin : g_drive
      assign client_o[i].op    = op_r[i];
      assign client_o[i].param = param_r[i];
   end

   // decoder comes out of reset waiting for a start bit
   a_idle_after_reset : assert property (@(posedge bsg_tag_i)
      $rose(arst_n_i) |-> (state_r == idle));

   // never more than one client addressed at once
   a_one_client : assert property (@(posedge bsg_tag_i) disable iff (!arst_n_i)
      $onehot0(op_r | param_r));

endmodule

// File: tag_top.sv
// two-client tag network; tag_en_i is shared by both clients and may only change between packets
`timescale 1ns/1ps

module tag_top
   import tag_pkg::*;
(
   input  logic          bsg_tag_i,
   input  logic          arst_n_i,
   input  logic          tag_data_i,
   input  logic          tag_en_i,
   input  logic          recv_clk_i,
   output logic          client0_new_o,
   output client0_data_t client0_data_o,
   output logic          client1_new_o,
   output client1_data_t client1_data_o
);

   // one link per client, clock and enable shared by both
   tag_if u_tag_if [num_clients_lp]
   (
      .clk_i (bsg_tag_i),
      .en_i  (tag_en_i)
   );

   // packet decoder
   tag_master u_master
   (
      .bsg_tag_i  (bsg_tag_i),
      .arst_n_i   (arst_n_i),
      .tag_data_i (tag_data_i),
      .client_o   (u_tag_if)
   );

   // client 0, address 0
   tag_client #(.width_p(client0_width_lp)) u_client0
   (
      .tag_i         (u_tag_if[0]),
      .recv_clk_i    (recv_clk_i),
      .arst_n_i      (arst_n_i),
      .recv_new_r_o  (client0_new_o),
      .recv_data_r_o (client0_data_o)
   );

   // client 1, address 1
   tag_client #(.width_p(client1_width_lp)) u_client1
   (
      .tag_i         (u_tag_if[1]),
      .recv_clk_i    (recv_clk_i),
      .arst_n_i      (arst_n_i),
      .recv_new_r_o  (client1_new_o),
      .recv_data_r_o (client1_data_o)
   );

endmodule

// File: tag_tb.sv
// each nonzero packet carries the full client width; recv edges fall on even ns and never meet stimulus at +1 ns
`timescale 1ns/1ps

module tag_tb
   import tag_pkg::*;
();

   localparam int tag_half_lp         = 4;
   localparam int recv_half_lp        = 3;
   localparam int reset_cycles_lp     = 8;
   localparam int gap_cycles_lp       = 20;
   localparam int num_packets_lp      = 17;
   localparam int cycles_per_packet_lp = 40;
   localparam int watchdog_ns_lp =
      (num_packets_lp * cycles_per_packet_lp + reset_cycles_lp) * 2 * tag_half_lp;
   localparam logic [31:0] seed_lp    = 32'h7657_eb36;

   logic          bsg_tag_i;
   logic          arst_n_i;
   logic          tag_data_i;
   logic          tag_en_i;
   logic          recv_clk_i;
   logic          client0_new_o;
   client0_data_t client0_data_o;
   logic          client1_new_o;
   client1_data_t client1_data_o;

   // expected value per client plus pulses owed and pulses seen
   client0_data_t exp0;
   client0_data_t held0;
   client1_data_t exp1;
   client1_data_t held1;
   int            want0;
   int            want1;
   int            got0;
   int            got1;
   int            errors;
   int            err_base;
   int            tests_passed;
   int            tests_failed;
   logic          in_gap;

   tag_top u_tag_top
   (
      .bsg_tag_i      (bsg_tag_i),
      .arst_n_i       (arst_n_i),
      .tag_data_i     (tag_data_i),
      .tag_en_i       (tag_en_i),
      .recv_clk_i     (recv_clk_i),
      .client0_new_o  (client0_new_o),
      .client0_data_o (client0_data_o),
      .client1_new_o  (client1_new_o),
      .client1_data_o (client1_data_o)
   );

   // tag clock with posedges at 4 mod 8
   initial
   begin
      bsg_tag_i = 1'b0;
      forever #(tag_half_lp) bsg_tag_i = ~bsg_tag_i;
   end

   // recv clock starts 1 ns late so its posedges fall at even times
   initial
   begin
      recv_clk_i = 1'b0;
      #1;
      forever #(recv_half_lp) recv_clk_i = ~recv_clk_i;
   end

   // count pulses, and latch what the client should hold afterwards
   always @(posedge recv_clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         got0 <= 0;
         got1 <= 0;
      end
      else
      begin
         if (client0_new_o)
         begin
            got0  <= got0 + 1;
            held0 <= exp0;
         end
         if (client1_new_o)
         begin
            got1  <= got1 + 1;
            held1 <= exp1;
         end
      end
   end

   // value presented with the pulse
   a_c0_value : assert property (@(posedge recv_clk_i) disable iff (!arst_n_i)
      client0_new_o |-> (client0_data_o == exp0))
   else
   begin
      $display("error client0_data_o got 0x%h exp 0x%h",
               $sampled(client0_data_o), $sampled(exp0));
      errors++;
   end

   a_c1_value : assert property (@(posedge recv_clk_i) disable iff (!arst_n_i)
      client1_new_o |-> (client1_data_o == exp1))
   else
   begin
      $display("error client1_data_o got 0x%h exp 0x%h",
               $sampled(client1_data_o), $sampled(exp1));
      errors++;
   end

   // data holds between pulses once loaded
   a_c0_hold : assert property (@(posedge recv_clk_i) disable iff (!arst_n_i)
      (got0 > 0 && !client0_new_o) |-> (client0_data_o == held0))
   else
   begin
      $display("error client0_data_o got 0x%h exp 0x%h",
               $sampled(client0_data_o), $sampled(held0));
      errors++;
   end

   a_c1_hold : assert property (@(posedge recv_clk_i) disable iff (!arst_n_i)
      (got1 > 0 && !client1_new_o) |-> (client1_data_o == held1))
   else
   begin
      $display("error client1_data_o got 0x%h exp 0x%h",
               $sampled(client1_data_o), $sampled(held1));
      errors++;
   end

   // a pulse only where an update is still owed
   a_c0_owed : assert property (@(posedge recv_clk_i) disable iff (!arst_n_i)
      client0_new_o |-> (got0 < want0))
   else
   begin
      $display("client0_new_o pulsed with no update pending");
      errors++;
   end

   a_c1_owed : assert property (@(posedge recv_clk_i) disable iff (!arst_n_i)
      client1_new_o |-> (got1 < want1))
   else
   begin
      $display("client1_new_o pulsed with no update pending");
      errors++;
   end

   // decoder is back in idle for the whole gap after a packet
   a_master_idle : assert property (@(posedge bsg_tag_i) disable iff (!arst_n_i)
      in_gap |-> (u_tag_top.u_master.state_r == idle))
   else
   begin
      $display("error state_r got 0x%h exp 0x%h",
               $sampled(u_tag_top.u_master.state_r), idle);
      errors++;
   end

   // one serial bit held across the next tag edge
   task automatic drive_bit(input logic b);
      @(posedge bsg_tag_i);
      #1;
      tag_data_i = b;
   endtask

   task automatic set_enable(input logic b);
      @(posedge bsg_tag_i);
      #1;
      tag_en_i = b;
   endtask

   // start, length lsb first, dnr, id, payload lsb first, then idle gap
   task automatic send_packet(input client_id_t pkt_id, input logic pkt_dnr,
                              input tag_len_t pkt_len, input logic [15:0] pkt_value);
      // expected value and owed pulse for a packet that the client will present
      if (pkt_dnr && tag_en_i && pkt_len != '0)
      begin
         if (pkt_id == 1'b0)
         begin
            exp0 = client0_data_t'(pkt_value);
            want0++;
         end
         else
         begin
            exp1 = client1_data_t'(pkt_value);
            want1++;
         end
      end
      in_gap = 1'b0;
      drive_bit(1'b1);
      for (int i = 0; i < tag_len_width_lp; i++)
         drive_bit(pkt_len[i]);
      drive_bit(pkt_dnr);
      drive_bit(pkt_id[0]);
      for (int i = 0; i < int'(pkt_len); i++)
         drive_bit(pkt_value[i]);
      drive_bit(1'b0);
      in_gap = 1'b1;
      repeat (gap_cycles_lp - 1)
         drive_bit(1'b0);
   endtask

   task automatic start_test();
      err_base = errors;
   endtask

   // pulses owed must all have arrived within the gap
   task automatic end_test(input string name);
      assert (got0 == want0)
      else
      begin
         $display("error client0 pulse count got 0x%h exp 0x%h", got0, want0);
         errors++;
      end
      assert (got1 == want1)
      else
      begin
         $display("error client1 pulse count got 0x%h exp 0x%h", got1, want1);
         errors++;
      end
      if (errors == err_base)
      begin
         tests_passed++;
         $display("test %s passed", name);
      end
      else
      begin
         tests_failed++;
         $display("test %s failed", name);
      end
   endtask

   initial
   begin
      void'($urandom(seed_lp));
      arst_n_i     = 1'b0;
      tag_data_i   = 1'b0;
      tag_en_i     = 1'b1;
      in_gap       = 1'b0;
      exp0         = '0;
      exp1         = '0;
      held0        = '0;
      held1        = '0;
      want0        = 0;
      want1        = 0;
      errors       = 0;
      err_base     = 0;
      tests_passed = 0;
      tests_failed = 0;
      repeat (reset_cycles_lp) @(posedge bsg_tag_i);
      #1;
      arst_n_i = 1'b1;

      // quiet line with nothing owed yet
      start_test();
      repeat (10) drive_bit(1'b0);
      end_test("after reset");

      start_test();
      send_packet(1'b0, 1'b0, tag_len_t'(client0_width_lp), 16'h0);
      send_packet(1'b0, 1'b1, tag_len_t'(client0_width_lp), 16'($urandom));
      end_test("reset and load");

      // client 0 must stay quiet and keep its value
      start_test();
      send_packet(1'b1, 1'b1, tag_len_t'(client1_width_lp), 16'($urandom));
      end_test("addressing");

      // receive side detached, then reattached with no stale pulse
      start_test();
      set_enable(1'b0);
      send_packet(1'b0, 1'b1, tag_len_t'(client0_width_lp), 16'($urandom));
      set_enable(1'b1);
      send_packet(1'b0, 1'b1, tag_len_t'(client0_width_lp), 16'($urandom));
      end_test("enable detach");

      start_test();
      for (int i = 0; i < 10; i++)
      begin
         if (i % 2 == 0)
            send_packet(1'b0, 1'b1, tag_len_t'(client0_width_lp), 16'($urandom));
         else
            send_packet(1'b1, 1'b1, tag_len_t'(client1_width_lp), 16'($urandom));
      end
      end_test("series of loads");

      start_test();
      send_packet(1'b0, 1'b1, tag_len_t'(0), 16'($urandom));
      send_packet(1'b1, 1'b1, tag_len_t'(client1_width_lp), 16'($urandom));
      end_test("zero length");

      $display("tests passed %0d failed %0d", tests_passed, tests_failed);
      if (errors == 0 && tests_failed == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

   // budget of 40 tag cycles per packet plus reset
   initial
   begin
      #(watchdog_ns_lp);
      $display("watchdog expired before the tests finished");
      $display("TEST FAIL");
      $finish;
   end

endmodule

// File: filelist.f
tag_pkg.sv
tag_if.sv
tag_sync.sv
tag_client.sv
tag_master.sv
tag_top.sv
tag_tb.sv
